// File: verilog.f
+incdir+test
verilog/exec_pkg.sv
verilog/alu_unit.sv
verilog/div_unit.sv
verilog/execute_stage.sv
test/execute_stage_tb.sv

// File: test/exec_model.svh
`ifndef exec_model_svh
`define exec_model_svh

// expected results for the single-cycle codes, 0 for anything else
function automatic logic [exec_pkg::xlen-1:0] alu_result_of(
    input logic [exec_pkg::exe_fun_w-1:0] fun,
    input logic [exec_pkg::xlen-1:0]      a,
    input logic [exec_pkg::xlen-1:0]      b
);
    logic [4:0] amount;
    amount = b[4:0];
    case (fun)
        exec_pkg::alu_add:   return a + b;
        exec_pkg::alu_sub:   return a - b;
        exec_pkg::alu_and:   return a & b;
        exec_pkg::alu_or:    return a | b;
        exec_pkg::alu_xor:   return a ^ b;
        exec_pkg::alu_sll:   return a << amount;
        exec_pkg::alu_srl:   return a >> amount;
        exec_pkg::alu_sra:   return $signed(a) >>> amount;
        exec_pkg::alu_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exec_pkg::alu_sltu:  return (a < b) ? 32'd1 : 32'd0;
        exec_pkg::alu_jalr:  return (a + b) & ~32'd1;
        exec_pkg::alu_copy1: return a;
        default:             return '0;
    endcase
endfunction

function automatic logic branch_taken(
    input logic [exec_pkg::exe_fun_w-1:0] fun,
    input logic [exec_pkg::xlen-1:0]      a,
    input logic [exec_pkg::xlen-1:0]      b
);
    case (fun)
        exec_pkg::br_beq:  return a == b;
        exec_pkg::br_bne:  return a != b;
        exec_pkg::br_blt:  return $signed(a) < $signed(b);
        exec_pkg::br_bge:  return $signed(a) >= $signed(b);
        exec_pkg::br_bltu: return a < b;
        exec_pkg::br_bgeu: return a >= b;
        default:           return 1'b0;
    endcase
endfunction

// rv32m divide and remainder, including the two special cases
function automatic logic [exec_pkg::xlen-1:0] divide_result_of(
    input logic [exec_pkg::exe_fun_w-1:0] fun,
    input logic [exec_pkg::xlen-1:0]      a,
    input logic [exec_pkg::xlen-1:0]      b
);
    logic                      signed_op;
    logic                      want_rem;
    logic [exec_pkg::xlen-1:0] q;
    logic [exec_pkg::xlen-1:0] r;
    signed_op = (fun == exec_pkg::alu_div) || (fun == exec_pkg::alu_rem);
    want_rem  = (fun == exec_pkg::alu_rem) || (fun == exec_pkg::alu_remu);
    if (b == '0) begin
        q = '1;
        r = a;
    end else if (signed_op && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        q = a;
        r = '0;
    end else if (signed_op) begin
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
    end else begin
        q = a / b;
        r = a % b;
    end
    return want_rem ? r : q;
endfunction

`endif

// File: test/execute_stage_tb.sv
`timescale 1ns/1ps

module execute_stage_tb;

    logic                              clk;
    logic                              rst_n;
    logic                              flush;
    logic                              stall_in;
    logic [exec_pkg::xlen-1:0]         pc;
    logic [exec_pkg::exe_fun_w-1:0]    exe_fun;
    logic [exec_pkg::xlen-1:0]         op1_data;
    logic [exec_pkg::xlen-1:0]         op2_data;
    logic [exec_pkg::xlen-1:0]         rs2_data;
    logic [exec_pkg::xlen-1:0]         imm_b_sext;
    logic [exec_pkg::mem_wen_w-1:0]    mem_wen;
    logic                              rf_wen;
    logic [exec_pkg::wb_sel_w-1:0]     wb_sel;
    logic [exec_pkg::reg_addr_w-1:0]   wb_addr;
    logic                              jmp_flg;
    logic [exec_pkg::xlen-1:0]         alu_out;
    logic                              br_flg;
    logic [exec_pkg::xlen-1:0]         br_target;
    logic                              stall_out;
    logic [exec_pkg::xlen-1:0]         pc_out;
    logic [exec_pkg::xlen-1:0]         rs2_data_out;
    logic [exec_pkg::mem_wen_w-1:0]    mem_wen_out;
    logic                              rf_wen_out;
    logic [exec_pkg::wb_sel_w-1:0]     wb_sel_out;
    logic [exec_pkg::reg_addr_w-1:0]   wb_addr_out;
    logic                              jmp_flg_out;

    int errors;
    int checks;

    logic [exec_pkg::exe_fun_w-1:0] single_codes [12] = '{
        exec_pkg::alu_add, exec_pkg::alu_sub, exec_pkg::alu_and, exec_pkg::alu_or,
        exec_pkg::alu_xor, exec_pkg::alu_sll, exec_pkg::alu_srl, exec_pkg::alu_sra,
        exec_pkg::alu_slt, exec_pkg::alu_sltu, exec_pkg::alu_jalr, exec_pkg::alu_copy1};
    logic [exec_pkg::exe_fun_w-1:0] branch_codes [6] = '{
        exec_pkg::br_beq, exec_pkg::br_bne, exec_pkg::br_blt,
        exec_pkg::br_bge, exec_pkg::br_bltu, exec_pkg::br_bgeu};
    logic [exec_pkg::exe_fun_w-1:0] divide_codes [4] = '{
        exec_pkg::alu_div, exec_pkg::alu_divu, exec_pkg::alu_rem, exec_pkg::alu_remu};
    // sign and shift corners paired by index
    logic [exec_pkg::xlen-1:0] corner_a [4] = '{32'h0, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
    logic [exec_pkg::xlen-1:0] corner_b [4] = '{32'h0, 32'h1, 32'hffff_ffe3, 32'h8000_0000};

    `include "exec_model.svh"

    execute_stage i_dut (.*);

    always #20 clk = ~clk;

    flush_clears_stall: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !stall_out)
        else begin
            errors++;
            $display("Fail stall_out expected 0 actual %h after a flush", $sampled(stall_out));
        end

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic randomize_fields();
        logic [31:0] r;
        r          = $urandom;
        pc         = $urandom & 32'hffff_fffc;
        rs2_data   = $urandom;
        imm_b_sext = {{19{r[12]}}, r[12:1], 1'b0};
        mem_wen    = r[16:13];
        rf_wen     = r[17];
        wb_sel     = r[21:18];
        wb_addr    = r[26:22];
        jmp_flg    = r[27];
    endtask

    // outputs must carry what was presented
    task automatic check_fields();
        expect_equal("pc_out", pc, pc_out);
        expect_equal("rs2_data_out", rs2_data, rs2_data_out);
        expect_equal("mem_wen_out", mem_wen, mem_wen_out);
        expect_equal("rf_wen_out", rf_wen, rf_wen_out);
        expect_equal("wb_sel_out", wb_sel, wb_sel_out);
        expect_equal("wb_addr_out", wb_addr, wb_addr_out);
        expect_equal("jmp_flg_out", jmp_flg, jmp_flg_out);
    endtask

    task automatic wait_stall_release();
        int waited;
        waited = 0;
        while (stall_out === 1'b1 && waited <= exec_pkg::div_cycles + 10) begin
            @(posedge clk);
            @(negedge clk);
            waited++;
        end
        if (waited > exec_pkg::div_cycles + 10) begin
            errors++;
            $display("stall_out never fell, the division did not finish");
            finish_run();
        end
    endtask

    task automatic issue_single(input logic [4:0] fun, input logic [31:0] a,
                                input logic [31:0] b);
        randomize_fields();
        exe_fun  = fun;
        op1_data = a;
        op2_data = b;
        #1;
        expect_equal("stall_out", 1'b0, stall_out);
        @(posedge clk);
        @(negedge clk);
        expect_equal("alu_out", alu_result_of(fun, a, b), alu_out);
        expect_equal("br_flg", branch_taken(fun, a, b), br_flg);
        expect_equal("br_target", pc + imm_b_sext, br_target);
        check_fields();
    endtask

    task automatic issue_divide(input logic [4:0] fun, input logic [31:0] a,
                                input logic [31:0] b, input bit hold_mem);
        logic [31:0] expected;
        randomize_fields();
        exe_fun  = fun;
        op1_data = a;
        op2_data = b;
        stall_in = hold_mem;
        expected = divide_result_of(fun, a, b);
        #1;
        expect_equal("stall_out", 1'b1, stall_out);
        wait_stall_release();
        if (hold_mem) begin
            // memory stage keeps stalling past the divider finishing
            repeat (3) begin
                @(posedge clk);
                @(negedge clk);
                expect_equal("alu_out", expected, alu_out);
                expect_equal("stall_out", 1'b0, stall_out);
            end
            stall_in = 1'b0;
        end
        @(posedge clk);
        @(negedge clk);
        expect_equal("alu_out", expected, alu_out);
        check_fields();
    endtask

    task automatic flush_division(input logic [31:0] a, input logic [31:0] b);
        randomize_fields();
        exe_fun  = exec_pkg::alu_div;
        op1_data = a;
        op2_data = b;
        rf_wen   = 1'b1;
        jmp_flg  = 1'b1;
        mem_wen  = 4'h5;
        repeat (5) begin
            @(posedge clk);
            @(negedge clk);
        end
        expect_equal("stall_out", 1'b1, stall_out);
        flush   = 1'b1;
        exe_fun = exec_pkg::alu_x;
        @(posedge clk);
        @(negedge clk);
        expect_equal("rf_wen_out", 1'b0, rf_wen_out);
        expect_equal("mem_wen_out", exec_pkg::men_x, mem_wen_out);
        expect_equal("br_flg", 1'b0, br_flg);
        expect_equal("jmp_flg_out", 1'b0, jmp_flg_out);
        // taken branch under a second flush cycle
        exe_fun  = exec_pkg::br_beq;
        op2_data = op1_data;
        #1;
        expect_equal("stall_out", 1'b0, stall_out);
        @(posedge clk);
        @(negedge clk);
        expect_equal("rf_wen_out", 1'b0, rf_wen_out);
        expect_equal("mem_wen_out", exec_pkg::men_x, mem_wen_out);
        expect_equal("br_flg", 1'b0, br_flg);
        expect_equal("jmp_flg_out", 1'b0, jmp_flg_out);
        flush = 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        stall_in   = 1'b0;
        pc         = '0;
        exe_fun    = exec_pkg::alu_x;
        op1_data   = '0;
        op2_data   = '0;
        rs2_data   = '0;
        imm_b_sext = '0;
        mem_wen    = exec_pkg::men_x;
        rf_wen     = 1'b0;
        wb_sel     = exec_pkg::wb_x;
        wb_addr    = '0;
        jmp_flg    = 1'b0;
        errors     = 0;
        checks     = 0;
        void'($urandom(32'heb38c4e4));

        repeat (2) @(posedge clk);
        @(negedge clk);
        expect_equal("alu_out", 32'h0, alu_out);
        expect_equal("br_target", 32'h0, br_target);
        expect_equal("br_flg", 1'b0, br_flg);
        expect_equal("rf_wen_out", 1'b0, rf_wen_out);
        expect_equal("jmp_flg_out", 1'b0, jmp_flg_out);
        expect_equal("mem_wen_out", exec_pkg::men_x, mem_wen_out);
        expect_equal("stall_out", 1'b0, stall_out);
        rst_n = 1'b1;

        foreach (single_codes[i]) begin
            foreach (corner_a[j])
                issue_single(single_codes[i], corner_a[j], corner_b[j]);
            repeat (4) issue_single(single_codes[i], $urandom, $urandom);
        end

        foreach (branch_codes[i]) begin
            foreach (corner_a[j])
                issue_single(branch_codes[i], corner_a[j], corner_b[j]);
            issue_single(branch_codes[i], 32'hffff_ffff, 32'h1);
            issue_single(branch_codes[i], 32'h1234_5678, 32'h1234_5678);
            repeat (3) issue_single(branch_codes[i], $urandom, $urandom);
        end

        foreach (divide_codes[i]) begin
            issue_divide(divide_codes[i], $urandom, 32'h0, 1'b0);
            issue_divide(divide_codes[i], 32'h8000_0000, 32'hffff_ffff, 1'b0);
            issue_divide(divide_codes[i], 32'hffff_fff9, 32'h2, 1'b0);
            repeat (3) issue_divide(divide_codes[i], $urandom, $urandom, 1'b0);
            issue_divide(divide_codes[i], $urandom, $urandom >> 20, 1'b1);
        end

        flush_division($urandom, $urandom);
        issue_single(exec_pkg::alu_add, $urandom, $urandom);
        issue_divide(exec_pkg::alu_rem, $urandom, $urandom >> 8, 1'b0);

        finish_run();
    end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              flush,
    input  logic                              stall_in,

    input  logic [exec_pkg::xlen-1:0]         pc,
    input  logic [exec_pkg::exe_fun_w-1:0]    exe_fun,
    input  logic [exec_pkg::xlen-1:0]         op1_data,
    input  logic [exec_pkg::xlen-1:0]         op2_data,
    input  logic [exec_pkg::xlen-1:0]         rs2_data,
    input  logic [exec_pkg::xlen-1:0]         imm_b_sext,
    input  logic [exec_pkg::mem_wen_w-1:0]    mem_wen,
    input  logic                              rf_wen,
    input  logic [exec_pkg::wb_sel_w-1:0]     wb_sel,
    input  logic [exec_pkg::reg_addr_w-1:0]   wb_addr,
    input  logic                              jmp_flg,

    output logic [exec_pkg::xlen-1:0]         alu_out,
    output logic                              br_flg,
    output logic [exec_pkg::xlen-1:0]         br_target,
    output logic                              stall_out,

    output logic [exec_pkg::xlen-1:0]         pc_out,
    output logic [exec_pkg::xlen-1:0]         rs2_data_out,
    output logic [exec_pkg::mem_wen_w-1:0]    mem_wen_out,
    output logic                              rf_wen_out,
    output logic [exec_pkg::wb_sel_w-1:0]     wb_sel_out,
    output logic [exec_pkg::reg_addr_w-1:0]   wb_addr_out,
    output logic                              jmp_flg_out
);

    // saved copy of the operation
    logic [exec_pkg::xlen-1:0]       save_pc;
    logic [exec_pkg::exe_fun_w-1:0]  save_exe_fun;
    logic [exec_pkg::xlen-1:0]       save_op1;
    logic [exec_pkg::xlen-1:0]       save_op2;
    logic [exec_pkg::xlen-1:0]       save_rs2;
    logic [exec_pkg::xlen-1:0]       save_imm_b;
    logic [exec_pkg::mem_wen_w-1:0]  save_mem_wen;
    logic                            save_rf_wen;
    logic [exec_pkg::wb_sel_w-1:0]   save_wb_sel;
    logic [exec_pkg::reg_addr_w-1:0] save_wb_addr;
    logic                            save_jmp_flg;

    // operation being computed this cycle
    logic                            use_saved;
    logic [exec_pkg::xlen-1:0]       cur_pc;
    logic [exec_pkg::exe_fun_w-1:0]  cur_exe_fun;
    logic [exec_pkg::xlen-1:0]       cur_op1;
    logic [exec_pkg::xlen-1:0]       cur_op2;
    logic [exec_pkg::xlen-1:0]       cur_rs2;
    logic [exec_pkg::xlen-1:0]       cur_imm_b;
    logic [exec_pkg::mem_wen_w-1:0]  cur_mem_wen;
    logic                            cur_rf_wen;
    logic [exec_pkg::wb_sel_w-1:0]   cur_wb_sel;
    logic [exec_pkg::reg_addr_w-1:0] cur_wb_addr;
    logic                            cur_jmp_flg;

    logic [exec_pkg::xlen-1:0]       alu_result;
    logic                            alu_br_taken;
    logic                            cur_is_div;
    logic                            cur_is_rem;
    logic                            cur_is_signed;

    logic                            div_start;
    logic                            div_ready;
    logic                            div_valid;
    logic [exec_pkg::xlen-1:0]       div_quotient;
    logic [exec_pkg::xlen-1:0]       div_remainder;
    logic [exec_pkg::xlen-1:0]       div_result;

    logic                            calc_started;
    logic                            calc_done;
    logic [exec_pkg::xlen-1:0]       calc_result;
    logic [exec_pkg::xlen-1:0]       next_alu_out;

    assign cur_pc      = use_saved ? save_pc      : pc;
    assign cur_exe_fun = use_saved ? save_exe_fun : exe_fun;
    assign cur_op1     = use_saved ? save_op1     : op1_data;
    assign cur_op2     = use_saved ? save_op2     : op2_data;
    assign cur_rs2     = use_saved ? save_rs2     : rs2_data;
    assign cur_imm_b   = use_saved ? save_imm_b   : imm_b_sext;
    assign cur_mem_wen = use_saved ? save_mem_wen : mem_wen;
    assign cur_rf_wen  = use_saved ? save_rf_wen  : rf_wen;
    assign cur_wb_sel  = use_saved ? save_wb_sel  : wb_sel;
    assign cur_wb_addr = use_saved ? save_wb_addr : wb_addr;
    assign cur_jmp_flg = use_saved ? save_jmp_flg : jmp_flg;

    alu_unit i_alu (
        .exe_fun  (cur_exe_fun),
        .op1      (cur_op1),
        .op2      (cur_op2),
        .result   (alu_result),
        .br_taken (alu_br_taken),
        .is_div   (cur_is_div)
    );

    assign cur_is_rem    = (cur_exe_fun == exec_pkg::alu_rem) ||
                           (cur_exe_fun == exec_pkg::alu_remu);
    assign cur_is_signed = (cur_exe_fun == exec_pkg::alu_div) ||
                           (cur_exe_fun == exec_pkg::alu_rem);

    // new division, nothing running for it yet
    assign div_start = cur_is_div & ~calc_started & ~calc_done & div_ready;

    div_unit i_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .kill      (flush),
        .is_signed (cur_is_signed),
        .dividend  (cur_op1),
        .divisor   (cur_op2),
        .ready     (div_ready),
        .valid     (div_valid),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

    assign div_result = cur_is_rem ? div_remainder : div_quotient;

    // stall until the divider reports, or a result is already held
    assign stall_out = cur_is_div & ~calc_done & ~(calc_started & div_valid);

    assign next_alu_out = !cur_is_div ? alu_result :
                          calc_done   ? calc_result : div_result;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            use_saved    <= 1'b0;
            calc_started <= 1'b0;
            calc_done    <= 1'b0;
        end else begin
            use_saved <= stall_out | stall_in;
            if (div_start) begin
                calc_started <= 1'b1;
            end else if (calc_started && div_valid) begin
                calc_started <= 1'b0;
                // memory stage still busy, keep the result around
                calc_done    <= stall_in;
            end else if (!stall_in && !stall_out) begin
                calc_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (calc_started && div_valid) begin
            calc_result <= div_result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            save_exe_fun <= exec_pkg::alu_x;
            save_mem_wen <= exec_pkg::men_x;
            save_rf_wen  <= 1'b0;
            save_jmp_flg <= 1'b0;
        end else begin
            save_exe_fun <= cur_exe_fun;
            save_mem_wen <= cur_mem_wen;
            save_rf_wen  <= cur_rf_wen;
            save_jmp_flg <= cur_jmp_flg;
        end
    end

    always_ff @(posedge clk) begin
        save_pc      <= cur_pc;
        save_op1     <= cur_op1;
        save_op2     <= cur_op2;
        save_rs2     <= cur_rs2;
        save_imm_b   <= cur_imm_b;
        save_wb_sel  <= cur_wb_sel;
        save_wb_addr <= cur_wb_addr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            alu_out      <= '0;
            br_flg       <= 1'b0;
            br_target    <= '0;
            pc_out       <= '0;
            rs2_data_out <= '0;
            mem_wen_out  <= exec_pkg::men_x;
            rf_wen_out   <= 1'b0;
            wb_sel_out   <= exec_pkg::wb_x;
            wb_addr_out  <= '0;
            jmp_flg_out  <= 1'b0;
        end else begin
            alu_out      <= next_alu_out;
            br_flg       <= alu_br_taken;
            br_target    <= cur_pc + cur_imm_b;
            pc_out       <= cur_pc;
            rs2_data_out <= cur_rs2;
            mem_wen_out  <= cur_mem_wen;
            rf_wen_out   <= cur_rf_wen;
            wb_sel_out   <= cur_wb_sel;
            wb_addr_out  <= cur_wb_addr;
            jmp_flg_out  <= cur_jmp_flg;
        end
    end

endmodule

// File: verilog/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      kill,
    input  logic                      is_signed,
    input  logic [exec_pkg::xlen-1:0] dividend,
    input  logic [exec_pkg::xlen-1:0] divisor,
    output logic                      ready,
    output logic                      valid,
    output logic [exec_pkg::xlen-1:0] quotient,
    output logic [exec_pkg::xlen-1:0] remainder
);

    logic                           busy;
    logic [exec_pkg::div_cnt_w-1:0] step_cnt;
    logic                           last_step;

    // iteration state
    logic [exec_pkg::xlen-1:0]      part_rem;
    logic [exec_pkg::xlen-1:0]      quo_shift;
    logic [exec_pkg::xlen-1:0]      dvs_mag;
    logic [exec_pkg::xlen-1:0]      dvd_orig;
    logic                           neg_quo;
    logic                           neg_rem;
    logic                           dvs_zero;

    logic                           dvd_neg;
    logic                           dvs_neg;
    logic [exec_pkg::xlen-1:0]      dvd_abs;
    logic [exec_pkg::xlen-1:0]      dvs_abs;

    logic [exec_pkg::xlen:0]        trial;
    logic [exec_pkg::xlen:0]        diff;
    logic [exec_pkg::xlen-1:0]      next_rem;
    logic [exec_pkg::xlen-1:0]      next_quo;

    // magnitudes of the operands
    assign dvd_neg = is_signed & dividend[exec_pkg::xlen-1];
    assign dvs_neg = is_signed & divisor[exec_pkg::xlen-1];
    assign dvd_abs = dvd_neg ? -dividend : dividend;
    assign dvs_abs = dvs_neg ? -divisor : divisor;

    // one restoring step: shift in the next dividend bit, try a subtract
    assign trial    = {part_rem, quo_shift[exec_pkg::xlen-1]};
    assign diff     = trial - {1'b0, dvs_mag};
    assign next_rem = diff[exec_pkg::xlen] ? trial[exec_pkg::xlen-1:0]
                                           : diff[exec_pkg::xlen-1:0];
    assign next_quo = {quo_shift[exec_pkg::xlen-2:0], ~diff[exec_pkg::xlen]};

    assign last_step = (step_cnt == exec_pkg::div_cnt_w'(exec_pkg::div_cycles - 1));
    assign ready     = ~busy;

    always_ff @(posedge clk) begin
        if (!rst_n || kill) begin
            busy     <= 1'b0;
            valid    <= 1'b0;
            step_cnt <= '0;
        end else begin
            valid <= 1'b0;
            if (start && !busy) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    busy  <= 1'b0;
                    valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            part_rem  <= '0;
            quo_shift <= dvd_abs;
            dvs_mag   <= dvs_abs;
            dvd_orig  <= dividend;
            neg_quo   <= dvd_neg ^ dvs_neg;
            // remainder follows the dividend sign
            neg_rem   <= dvd_neg;
            dvs_zero  <= (divisor == '0);
        end else if (busy && !kill) begin
            part_rem  <= next_rem;
            quo_shift <= next_quo;
            if (last_step) begin
                if (dvs_zero) begin
                    quotient  <= '1;
                    remainder <= dvd_orig;
                end else begin
                    // min / -1 lands here too: both signs negative, so the
                    // magnitude quotient 0x80000000 passes unchanged, rem is 0
                    quotient  <= neg_quo ? -next_quo : next_quo;
                    remainder <= neg_rem ? -next_rem : next_rem;
                end
            end
        end
    end

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic [exec_pkg::exe_fun_w-1:0] exe_fun,
    input  logic [exec_pkg::xlen-1:0]      op1,
    input  logic [exec_pkg::xlen-1:0]      op2,
    output logic [exec_pkg::xlen-1:0]      result,
    output logic                           br_taken,
    output logic                           is_div
);

    logic [$clog2(exec_pkg::xlen)-1:0] shamt;
    logic [exec_pkg::xlen-1:0]         sum;
    logic                              equal;
    logic                              less_s;
    logic                              less_u;

    assign shamt  = op2[$clog2(exec_pkg::xlen)-1:0];
    assign sum    = op1 + op2;
    assign equal  = (op1 == op2);
    assign less_s = ($signed(op1) < $signed(op2));
    assign less_u = (op1 < op2);

    always_comb begin
        case (exe_fun)
            exec_pkg::alu_add:   result = sum;
            exec_pkg::alu_sub:   result = op1 - op2;
            exec_pkg::alu_and:   result = op1 & op2;
            exec_pkg::alu_or:    result = op1 | op2;
            exec_pkg::alu_xor:   result = op1 ^ op2;
            exec_pkg::alu_sll:   result = op1 << shamt;
            exec_pkg::alu_srl:   result = op1 >> shamt;
            exec_pkg::alu_sra:   result = $signed(op1) >>> shamt;
            exec_pkg::alu_slt:   result = {{(exec_pkg::xlen-1){1'b0}}, less_s};
            exec_pkg::alu_sltu:  result = {{(exec_pkg::xlen-1){1'b0}}, less_u};
            // jalr target drops bit 0
            exec_pkg::alu_jalr:  result = {sum[exec_pkg::xlen-1:1], 1'b0};
            exec_pkg::alu_copy1: result = op1;
            default:             result = '0;
        endcase
    end

    always_comb begin
        case (exe_fun)
            exec_pkg::br_beq:  br_taken = equal;
            exec_pkg::br_bne:  br_taken = ~equal;
            exec_pkg::br_blt:  br_taken = less_s;
            exec_pkg::br_bge:  br_taken = ~less_s;
            exec_pkg::br_bltu: br_taken = less_u;
            exec_pkg::br_bgeu: br_taken = ~less_u;
            default:           br_taken = 1'b0;
        endcase
    end

    // divide and remainder go to the divider instead
    assign is_div = (exe_fun == exec_pkg::alu_div)  ||
                    (exe_fun == exec_pkg::alu_divu) ||
                    (exe_fun == exec_pkg::alu_rem)  ||
                    (exe_fun == exec_pkg::alu_remu);

endmodule

// File: verilog/exec_pkg.sv
package exec_pkg;

    // data and field widths
    localparam int xlen       = 32;
    localparam int exe_fun_w  = 5;
    localparam int mem_wen_w  = 4;
    localparam int wb_sel_w   = 4;
    localparam int reg_addr_w = 5;

    // divider iterations, one quotient bit per step
    localparam int div_cycles = xlen;
    localparam int div_cnt_w  = $clog2(div_cycles);

    // no operation
    localparam logic [exe_fun_w-1:0] alu_x     = 5'd0;

    // single-cycle integer operations
    localparam logic [exe_fun_w-1:0] alu_add   = 5'd1;
    localparam logic [exe_fun_w-1:0] alu_sub   = 5'd2;
    localparam logic [exe_fun_w-1:0] alu_and   = 5'd3;
    localparam logic [exe_fun_w-1:0] alu_or    = 5'd4;
    localparam logic [exe_fun_w-1:0] alu_xor   = 5'd5;
    localparam logic [exe_fun_w-1:0] alu_sll   = 5'd6;
    localparam logic [exe_fun_w-1:0] alu_srl   = 5'd7;
    localparam logic [exe_fun_w-1:0] alu_sra   = 5'd8;
    localparam logic [exe_fun_w-1:0] alu_slt   = 5'd9;
    localparam logic [exe_fun_w-1:0] alu_sltu  = 5'd10;

    // branch compares
    localparam logic [exe_fun_w-1:0] br_beq    = 5'd11;
    localparam logic [exe_fun_w-1:0] br_bne    = 5'd12;
    localparam logic [exe_fun_w-1:0] br_blt    = 5'd13;
    localparam logic [exe_fun_w-1:0] br_bge    = 5'd14;
    localparam logic [exe_fun_w-1:0] br_bltu   = 5'd15;
    localparam logic [exe_fun_w-1:0] br_bgeu   = 5'd16;

    // jump and copy
    localparam logic [exe_fun_w-1:0] alu_jalr  = 5'd17;
    localparam logic [exe_fun_w-1:0] alu_copy1 = 5'd18;

    // rv32m divide and remainder, multi-cycle
    localparam logic [exe_fun_w-1:0] alu_div   = 5'd19;
    localparam logic [exe_fun_w-1:0] alu_divu  = 5'd20;
    localparam logic [exe_fun_w-1:0] alu_rem   = 5'd21;
    localparam logic [exe_fun_w-1:0] alu_remu  = 5'd22;

    // inactive control field values
    localparam logic [mem_wen_w-1:0] men_x     = 4'd0;
    localparam logic [wb_sel_w-1:0]  wb_x      = 4'd0;

endpackage
